// ==== Makefile ====
VERILATOR = verilator
VFLAGS    = --binary --timing --assert --timescale 1ns/1ps -Wno-fatal
TOP       = tb_sd_cmd_top
FILELIST  = filelist.f
OBJ_DIR   = obj_dir
PASS_MSG  = Finished with no errors

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJ_DIR)

run: compile
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

// ==== filelist.f ====
rtl/sd_bus_pkg.sv
rtl/sd_cmd_pkg.sv
rtl/sd_clk_div.sv
rtl/cmd_write.sv
rtl/rsp_read.sv
rtl/cmd_wrap.sv
rtl/sd_cmd_top.sv
testbench/sd_card_model.sv
testbench/tb_sd_cmd_top.sv

// ==== rtl/cmd_wrap.sv ====
`timescale 1ns/1ps

module cmd_wrap import sd_bus_pkg::*, sd_cmd_pkg::*; (
  input  logic        clk_i,
  input  logic        rst_ni,
  input  logic        clk_en_p_i,
  input  logic        clk_en_n_i,
  input  logic        cmd_start_i,
  input  logic [5:0]  cmd_index_i,
  input  logic [31:0] cmd_arg_i,
  input  rsp_type_e   rsp_type_i,
  input  logic        crc_check_en_i,
  input  logic        index_check_en_i,
  input  logic        sd_cmd_i,
  input  logic        sd_dat0_i,
  output logic        sd_cmd_o,
  output logic        sd_cmd_en_o,
  output logic        cmd_inhibit_o,
  output logic        cmd_done_o,
  output logic        rsp_done_o,
  output logic [31:0] rsp_word0_o,
  output logic [31:0] rsp_word1_o,
  output logic [31:0] rsp_word2_o,
  output logic [31:0] rsp_word3_o,
  output logic        err_timeout_o,
  output logic        err_crc_o,
  output logic        err_end_bit_o,
  output logic        err_index_o
);

  cmd_seq_state_e              state_q, state_d;
  rsp_type_e                   rsp_type_q;
  logic [CNT_WIDTH-1:0]        cnt_q, cnt_d;
  logic [5:0]                  index_q;
  logic                        start_req_q, rsp_got_q, crc_chk_q, idx_chk_q;
  logic                        start_tx, tx_done, start_listening, receiving, rsp_valid;
  logic                        crc_ok, end_bit_err, rsp_state, timeout, rsp_upd;
  logic [RSP_PAYLOAD_BITS-1:0] rsp;

  assign cmd_inhibit_o = start_req_q | (state_q != READY);
  assign start_tx      = cmd_start_i & ~cmd_inhibit_o;  // strobes while inhibited are dropped

  always_ff @(posedge clk_i) begin
    if (!rst_ni) begin
      start_req_q <= 1'b0;
      rsp_type_q  <= RSP_NONE;
      crc_chk_q   <= 1'b0;
      idx_chk_q   <= 1'b0;
    end else if (start_tx) begin
      start_req_q <= 1'b1;
      rsp_type_q  <= rsp_type_i;
      crc_chk_q   <= crc_check_en_i;
      idx_chk_q   <= index_check_en_i;
    end else if (clk_en_p_i && state_q == READY) begin
      start_req_q <= 1'b0;  // taken by the sequencer
    end
  end

  always_ff @(posedge clk_i) begin
    if (start_tx) index_q <= cmd_index_i;
  end

  //////////////////////////////
  // command sequencer
  //////////////////////////////

  assign rsp_state = (state_q == READ_RSP) || (state_q == READ_RSP_BUSY);
  assign timeout   = rsp_state & ~receiving & ~rsp_got_q
                   & (cnt_q >= CNT_WIDTH'(RSP_TIMEOUT_CYCLES - 2));
  assign rsp_upd   = clk_en_p_i & rsp_state & rsp_valid;

  always_comb begin
    state_d = state_q;
    unique case (state_q)
      READY:         if (start_req_q) state_d = WRITE_CMD;
      WRITE_CMD:     if (tx_done) state_d = (rsp_type_q == RSP_NONE) ? RSP_RECEIVED : BUS_SWITCH;
      BUS_SWITCH:    state_d = (rsp_type_q == RSP_SHORT_BUSY) ? READ_RSP_BUSY : READ_RSP;
      READ_RSP:      if (timeout || rsp_valid) state_d = RSP_RECEIVED;
      READ_RSP_BUSY: if (timeout || (rsp_got_q && sd_dat0_i)) state_d = RSP_RECEIVED;
      RSP_RECEIVED:  if (cnt_q == CNT_WIDTH'(NRC_CYCLES - 1)) state_d = READY;
      default:       state_d = READY;
    endcase
  end

  always_comb begin
    cnt_d = '0;
    if (rsp_state) cnt_d = (receiving || rsp_got_q) ? '0 : cnt_q + 1'b1;  // timeout count
    else if (state_q == RSP_RECEIVED) cnt_d = cnt_q + 1'b1;               // N_RC gap
    if (state_d != state_q) cnt_d = '0;
  end

  always_ff @(posedge clk_i) begin
    if (!rst_ni) begin
      state_q   <= READY;
      cnt_q     <= '0;
      rsp_got_q <= 1'b0;
    end else if (clk_en_p_i) begin
      state_q   <= state_d;
      cnt_q     <= cnt_d;
      rsp_got_q <= (state_q == BUS_SWITCH) ? 1'b0 : (rsp_got_q | rsp_valid);
    end
  end

  assign start_listening = (state_q == BUS_SWITCH) || (state_q == READ_RSP)
                         || (state_q == READ_RSP_BUSY && !rsp_got_q);

  assign cmd_done_o    = clk_en_p_i & ((state_q == BUS_SWITCH)
                       | (state_q == WRITE_CMD & tx_done & rsp_type_q == RSP_NONE));
  assign rsp_done_o    = clk_en_p_i & (state_q == RSP_RECEIVED) & (state_d == READY);
  assign err_timeout_o = clk_en_p_i & timeout;
  assign err_crc_o     = rsp_upd & crc_chk_q & ~crc_ok;
  assign err_end_bit_o = rsp_upd & end_bit_err;
  assign err_index_o   = rsp_upd & idx_chk_q & (rsp_type_q != RSP_LONG)
                       & (rsp[37:32] != index_q);  // index sits above the card status

  always_ff @(posedge clk_i) begin
    if (rsp_upd) begin
      rsp_word0_o <= rsp[31:0];
      if (rsp_type_q == RSP_LONG) begin
        rsp_word1_o <= rsp[63:32];
        rsp_word2_o <= rsp[95:64];
        rsp_word3_o <= {8'h00, rsp[119:96]};
      end
    end
  end

  cmd_write i_cmd_write (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .clk_en_n_i     (clk_en_n_i),
    .start_tx_i     (start_tx),
    .cmd_nr_i       (cmd_index_i),
    .cmd_argument_i (cmd_arg_i),
    .cmd_o          (sd_cmd_o),
    .cmd_en_o       (sd_cmd_en_o),
    .tx_done_o      (tx_done)
  );

  rsp_read i_rsp_read (
    .clk_i             (clk_i),
    .rst_ni            (rst_ni),
    .clk_en_i          (clk_en_p_i),
    .cmd_i             (sd_cmd_i),
    .long_rsp_i        (rsp_type_q == RSP_LONG),
    .start_listening_i (start_listening),
    .receiving_o       (receiving),
    .rsp_valid_o       (rsp_valid),
    .rsp_o             (rsp),
    .crc_ok_o          (crc_ok),
    .end_bit_err_o     (end_bit_err)
  );

  a_done_exclusive : assert property (@(posedge clk_i) disable iff (!rst_ni)
    !(rsp_done_o && cmd_done_o));

endmodule

// ==== rtl/cmd_write.sv ====
`timescale 1ns/1ps

module cmd_write import sd_bus_pkg::*; (
  input  logic        clk_i,
  input  logic        rst_ni,
  input  logic        clk_en_n_i,      // bits change after the falling sd edge
  input  logic        start_tx_i,
  input  logic [5:0]  cmd_nr_i,
  input  logic [31:0] cmd_argument_i,
  output logic        cmd_o,
  output logic        cmd_en_o,
  output logic        tx_done_o        // high while the end bit is on the line
);

  logic [39:0] sh_q;    // start, transmission bit, index, argument
  logic [6:0]  crc_q;
  logic [5:0]  cnt_q;   // bits already driven
  logic        busy_q;
  logic        cmd_q;
  logic        cmd_en_q;
  logic        shift;

  assign shift = clk_en_n_i & busy_q & (cnt_q < 6'(CMD_FRAME_BITS - CRC7_WIDTH - 1));

  always_ff @(posedge clk_i) begin
    if (!rst_ni) begin
      busy_q   <= 1'b0;
      cnt_q    <= 6'd0;
      crc_q    <= '0;
      cmd_q    <= 1'b1;
      cmd_en_q <= 1'b0;
    end else if (start_tx_i) begin
      busy_q <= 1'b1;
      cnt_q  <= 6'd0;
      crc_q  <= '0;
    end else if (clk_en_n_i && busy_q) begin
      cnt_q    <= cnt_q + 6'd1;
      cmd_en_q <= 1'b1;
      if (shift) begin
        cmd_q <= sh_q[39];
        crc_q <= crc7_next(crc_q, sh_q[39]);
      end else if (cnt_q < 6'(CMD_FRAME_BITS - 1)) begin
        cmd_q <= crc_q[CRC7_WIDTH-1];  // crc goes out msb first
        crc_q <= {crc_q[CRC7_WIDTH-2:0], 1'b0};
      end else if (cnt_q == 6'(CMD_FRAME_BITS - 1)) begin
        cmd_q <= 1'b1;  // end bit
      end else begin
        busy_q   <= 1'b0;  // release the line
        cmd_en_q <= 1'b0;
        cmd_q    <= 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (start_tx_i) begin
      sh_q <= {1'b0, 1'b1, cmd_nr_i, cmd_argument_i};
    end else if (shift) begin
      sh_q <= {sh_q[38:0], 1'b0};
    end
  end

  assign cmd_o     = cmd_q;
  assign cmd_en_o  = cmd_en_q;
  assign tx_done_o = busy_q & (cnt_q == 6'(CMD_FRAME_BITS));

  // the sequencer holds off new commands until the frame is out
  a_no_restart : assert property (@(posedge clk_i) disable iff (!rst_ni)
    start_tx_i |-> !busy_q);

endmodule

// ==== rtl/rsp_read.sv ====
`timescale 1ns/1ps

module rsp_read import sd_bus_pkg::*; (
  input  logic                        clk_i,
  input  logic                        rst_ni,
  input  logic                        clk_en_i,          // sample before the rising sd edge
  input  logic                        cmd_i,
  input  logic                        long_rsp_i,
  input  logic                        start_listening_i,
  output logic                        receiving_o,
  output logic                        rsp_valid_o,
  output logic [RSP_PAYLOAD_BITS-1:0] rsp_o,
  output logic                        crc_ok_o,
  output logic                        end_bit_err_o
);

  logic                        receiving_q;
  logic                        valid_q;
  logic                        end_err_q;
  logic [7:0]                  pos_q;     // bits taken so far
  logic [CRC7_WIDTH-1:0]       crc_q;
  logic [RSP_PAYLOAD_BITS-1:0] sh_q;

  logic [7:0]                  cur_pos;
  logic [7:0]                  last_pos;
  logic [7:0]                  msg_lo;
  logic [7:0]                  msg_hi;
  logic                        take_bit;
  logic                        in_msg;
  logic                        in_crc;
  logic [CRC7_WIDTH-1:0]       crc_base;
  logic [RSP_PAYLOAD_BITS-1:0] sh_base;

  //////////////////////////////
  // frame positions
  //////////////////////////////

  assign last_pos = long_rsp_i ? 8'(RSP_LONG_BITS - 1) : 8'(RSP_SHORT_BITS - 1);
  assign msg_hi   = last_pos - 8'(CRC7_WIDTH + 1);
  // R2 crc skips start, transmission and reserved bits
  assign msg_lo   = long_rsp_i ? 8'(RSP_LONG_BITS - RSP_PAYLOAD_BITS - CRC7_WIDTH - 1) : 8'd0;

  assign cur_pos  = receiving_q ? pos_q : 8'd0;  // start bit is position 0
  assign take_bit = clk_en_i & start_listening_i & (receiving_q | (~cmd_i & ~valid_q));
  assign in_msg   = (cur_pos >= msg_lo) && (cur_pos <= msg_hi);
  assign in_crc   = (cur_pos >= msg_lo) && (cur_pos < last_pos);  // message plus crc field
  assign crc_base = receiving_q ? crc_q : '0;
  assign sh_base  = receiving_q ? sh_q : '0;

  always_ff @(posedge clk_i) begin
    if (!rst_ni) begin
      receiving_q <= 1'b0;
      valid_q     <= 1'b0;
      end_err_q   <= 1'b0;
      pos_q       <= 8'd0;
      crc_q       <= '0;
    end else if (clk_en_i) begin
      valid_q <= 1'b0;
      if (!start_listening_i) begin
        receiving_q <= 1'b0;
      end else if (take_bit) begin
        pos_q <= cur_pos + 8'd1;
        crc_q <= in_crc ? crc7_next(crc_base, cmd_i) : crc_base;
        if (cur_pos == last_pos) begin
          receiving_q <= 1'b0;
          valid_q     <= 1'b1;
          end_err_q   <= ~cmd_i;
        end else begin
          receiving_q <= 1'b1;
        end
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (take_bit) begin
      sh_q <= in_msg ? {sh_base[RSP_PAYLOAD_BITS-2:0], cmd_i} : sh_base;
    end
  end

  assign receiving_o   = receiving_q;
  assign rsp_valid_o   = valid_q;
  assign rsp_o         = sh_q;
  assign crc_ok_o      = (crc_q == '0);  // remainder is zero when the received crc matches
  assign end_bit_err_o = end_err_q;

endmodule

// ==== rtl/sd_bus_pkg.sv ====
package sd_bus_pkg;

  //////////////////////////////
  // frame lengths on the CMD line
  //////////////////////////////

  localparam int unsigned CMD_FRAME_BITS   = 48;   // start, dir, index, arg, crc, end
  localparam int unsigned RSP_SHORT_BITS   = 48;   // R1, R3, R6, R7
  localparam int unsigned RSP_LONG_BITS    = 136;  // R2
  localparam int unsigned RSP_PAYLOAD_BITS = 120;  // long: bits 127:8, short: 47:8 placed low
  localparam int unsigned CRC7_WIDTH       = 7;

  //////////////////////////////
  // crc7 with x^7 + x^3 + 1
  //////////////////////////////

  // one serial step, msb first, initial value zero
  function automatic logic [CRC7_WIDTH-1:0] crc7_next(
    input logic [CRC7_WIDTH-1:0] crc,
    input logic                  din
  );
    logic fb;
    fb = din ^ crc[CRC7_WIDTH-1];
    return {crc[CRC7_WIDTH-2:0], 1'b0} ^ {3'b000, fb, 2'b00, fb};
  endfunction

endpackage

// ==== rtl/sd_clk_div.sv ====
`timescale 1ns/1ps

module sd_clk_div (
  input  logic       clk_i,
  input  logic       rst_ni,
  input  logic [7:0] clk_div_i,   // half period is clk_div_i + 1 clk_i cycles
  output logic       sd_clk_o,
  output logic       clk_en_p_o,  // high in the cycle before sd_clk rises
  output logic       clk_en_n_o   // high in the cycle before sd_clk falls
);

  logic [7:0] cnt_q;
  logic       sd_clk_q;
  logic       expire;

  assign expire = (cnt_q == 8'd0);

  always_ff @(posedge clk_i) begin
    if (!rst_ni) begin
      cnt_q    <= 8'd0;
      sd_clk_q <= 1'b0;
    end else if (expire) begin
      cnt_q    <= clk_div_i;  // reload on every toggle
      sd_clk_q <= ~sd_clk_q;
    end else begin
      cnt_q <= cnt_q - 8'd1;
    end
  end

  assign sd_clk_o   = sd_clk_q;
  assign clk_en_p_o = expire & ~sd_clk_q;
  assign clk_en_n_o = expire & sd_clk_q;

  a_en_exclusive : assert property (@(posedge clk_i) disable iff (!rst_ni)
    !(clk_en_p_o && clk_en_n_o));

endmodule

// ==== rtl/sd_cmd_pkg.sv ====
package sd_cmd_pkg;

  // response type field as written by the host
  typedef enum logic [1:0] {
    RSP_NONE       = 2'b00,
    RSP_LONG       = 2'b01,  // 136 bit, R2
    RSP_SHORT      = 2'b10,  // 48 bit
    RSP_SHORT_BUSY = 2'b11   // 48 bit, busy on dat0 afterwards
  } rsp_type_e;

  typedef enum logic [2:0] {
    READY,
    WRITE_CMD,
    BUS_SWITCH,     // line turnaround before the response
    READ_RSP,
    READ_RSP_BUSY,  // response plus busy on dat0
    RSP_RECEIVED    // N_RC gap before the next command
  } cmd_seq_state_e;

  localparam int unsigned RSP_TIMEOUT_CYCLES = 64;  // sd clocks until a start bit
  localparam int unsigned NRC_CYCLES         = 8;
  localparam int unsigned CNT_WIDTH          = 6;

endpackage

// ==== rtl/sd_cmd_top.sv ====
`timescale 1ns/1ps

module sd_cmd_top import sd_cmd_pkg::*; (
  input  logic        clk_i,
  input  logic        rst_ni,
  // host side
  input  logic        cmd_start_i,
  input  logic [5:0]  cmd_index_i,
  input  logic [31:0] cmd_arg_i,
  input  rsp_type_e   rsp_type_i,
  input  logic        crc_check_en_i,
  input  logic        index_check_en_i,
  input  logic [7:0]  clk_div_i,
  output logic        cmd_inhibit_o,
  output logic        cmd_done_o,
  output logic        rsp_done_o,
  output logic [31:0] rsp_word0_o,
  output logic [31:0] rsp_word1_o,
  output logic [31:0] rsp_word2_o,
  output logic [31:0] rsp_word3_o,
  output logic        err_timeout_o,
  output logic        err_crc_o,
  output logic        err_end_bit_o,
  output logic        err_index_o,
  // sd card side
  output logic        sd_clk_o,
  output logic        sd_cmd_o,
  output logic        sd_cmd_en_o,
  input  logic        sd_cmd_i,
  input  logic        sd_dat0_i
);

  logic clk_en_p, clk_en_n;

  sd_clk_div i_sd_clk_div (
    .clk_i      (clk_i),
    .rst_ni     (rst_ni),
    .clk_div_i  (clk_div_i),
    .sd_clk_o   (sd_clk_o),
    .clk_en_p_o (clk_en_p),
    .clk_en_n_o (clk_en_n)
  );

  cmd_wrap i_cmd_wrap (
    .clk_i            (clk_i),
    .rst_ni           (rst_ni),
    .clk_en_p_i       (clk_en_p),
    .clk_en_n_i       (clk_en_n),
    .cmd_start_i      (cmd_start_i),
    .cmd_index_i      (cmd_index_i),
    .cmd_arg_i        (cmd_arg_i),
    .rsp_type_i       (rsp_type_i),
    .crc_check_en_i   (crc_check_en_i),
    .index_check_en_i (index_check_en_i),
    .sd_cmd_i         (sd_cmd_i),
    .sd_dat0_i        (sd_dat0_i),
    .sd_cmd_o         (sd_cmd_o),
    .sd_cmd_en_o      (sd_cmd_en_o),
    .cmd_inhibit_o    (cmd_inhibit_o),
    .cmd_done_o       (cmd_done_o),
    .rsp_done_o       (rsp_done_o),
    .rsp_word0_o      (rsp_word0_o),
    .rsp_word1_o      (rsp_word1_o),
    .rsp_word2_o      (rsp_word2_o),
    .rsp_word3_o      (rsp_word3_o),
    .err_timeout_o    (err_timeout_o),
    .err_crc_o        (err_crc_o),
    .err_end_bit_o    (err_end_bit_o),
    .err_index_o      (err_index_o)
  );

endmodule

// ==== testbench/sd_card_model.sv ====
`timescale 1ns/1ps

module sd_card_model import sd_bus_pkg::*, sd_cmd_pkg::*; (
  input  logic                        sd_clk_i,
  input  logic                        cmd_i,         // host drives, sampled on rising sd_clk
  input  logic                        cmd_en_i,
  input  rsp_type_e                   rsp_type_i,
  input  logic                        silent_i,
  input  logic                        crc_flip_i,
  input  logic                        bad_index_i,
  input  int unsigned                 busy_clks_i,
  input  logic [RSP_PAYLOAD_BITS-1:0] payload_i,
  output logic                        cmd_o,         // card drives after falling sd_clk
  output logic                        dat0_o,
  output logic [CMD_FRAME_BITS-1:0]   frame_o,
  output int unsigned                 frame_cnt_o
);

  logic [CMD_FRAME_BITS-1:0] sh;
  logic [RSP_LONG_BITS-1:0]  rsp;
  int                        nbits;
  int                        rsp_len;

  // crc7 by polynomial division, msb first
  function automatic logic [6:0] crc7_calc(input logic [RSP_LONG_BITS-1:0] d, input int n);
    logic [6:0] c;
    logic       fb;
    c = '0;
    for (int i = n - 1; i >= 0; i--) begin
      fb = d[i] ^ c[6];
      c  = {c[5:0], 1'b0} ^ (fb ? 7'h09 : 7'h00);
    end
    return c;
  endfunction

  task automatic send_response();
    logic [39:0] msg;
    logic [6:0]  crc;
    if (rsp_type_i == RSP_LONG) begin
      rsp_len = RSP_LONG_BITS;
      crc     = crc7_calc({16'h0, payload_i}, 120) ^ {6'b0, crc_flip_i};
      rsp     = {2'b00, 6'h3f, payload_i, crc, 1'b1};  // R2, crc skips the header
    end else begin
      rsp_len = RSP_SHORT_BITS;
      msg     = {2'b00, sh[45:40] ^ {5'b0, bad_index_i}, payload_i[31:0]};
      crc     = crc7_calc({96'h0, msg}, 40) ^ {6'b0, crc_flip_i};
      rsp     = {88'h0, msg, crc, 1'b1};
    end
    repeat (2) @(negedge sd_clk_i);  // short turnaround before the reply
    for (int i = rsp_len - 1; i >= 0; i--) begin
      cmd_o <= rsp[i];
      @(negedge sd_clk_i);
    end
    cmd_o <= 1'b1;
    if (rsp_type_i == RSP_SHORT_BUSY) begin
      dat0_o <= 1'b0;  // busy after the end bit
      repeat (busy_clks_i) @(negedge sd_clk_i);
      dat0_o <= 1'b1;
    end
  endtask

  initial begin
    cmd_o       = 1'b1;
    dat0_o      = 1'b1;
    frame_o     = '0;
    frame_cnt_o = 0;
    nbits       = 0;
    forever begin
      @(posedge sd_clk_i);
      if (cmd_en_i) begin
        sh    = {sh[CMD_FRAME_BITS-2:0], cmd_i};
        nbits = nbits + 1;
      end
      if (nbits == CMD_FRAME_BITS) begin
        nbits       = 0;
        frame_o     = sh;
        frame_cnt_o = frame_cnt_o + 1;
        if (rsp_type_i != RSP_NONE && !silent_i) send_response();
      end
    end
  end

endmodule

// ==== testbench/tb_sd_cmd_top.sv ====
`timescale 1ns/1ps

module tb_sd_cmd_top import sd_bus_pkg::*, sd_cmd_pkg::*; ();

  localparam logic [7:0]  CLK_DIV     = 8'd1;
  localparam int unsigned CYCLE_LIMIT = 6 * (CMD_FRAME_BITS + RSP_LONG_BITS
                                        + RSP_TIMEOUT_CYCLES + NRC_CYCLES)
                                        * (int'(CLK_DIV) + 1) * 2 * 2;
  // event counters kept by the monitor
  localparam int CMD_DONE     = 0;
  localparam int RSP_DONE     = 1;
  localparam int ERR_TMO      = 2;
  localparam int ERR_CRC      = 3;
  localparam int ERR_END      = 4;
  localparam int ERR_IDX      = 5;
  localparam int DONE_IN_BUSY = 6;
  localparam int DAT0_LOW     = 7;

  logic        clk, rst_n, cmd_start, crc_check_en, index_check_en;
  logic [5:0]  cmd_index;
  logic [31:0] cmd_arg;
  rsp_type_e   rsp_type;
  logic        cmd_inhibit, cmd_done, rsp_done;
  logic [31:0] rsp_word0, rsp_word1, rsp_word2, rsp_word3;
  logic        err_timeout, err_crc, err_end_bit, err_index;
  logic        sd_clk, cmd_line_host, cmd_line_en, cmd_line_card, sd_dat0;

  rsp_type_e        card_rsp_type;
  logic             card_silent, card_crc_flip, card_bad_index;
  int unsigned      card_busy_clks;
  logic [119:0]     card_payload;
  logic [47:0]      card_frame;
  int unsigned      card_frames;

  int unsigned seen [8];
  int unsigned base [8];
  int unsigned cycles;
  int unsigned tests, checks, errors;
  logic        test_ok;
  logic [31:0] lfsr;

  sd_cmd_top dut_i (
    .clk_i (clk), .rst_ni (rst_n), .cmd_start_i (cmd_start), .cmd_index_i (cmd_index),
    .cmd_arg_i (cmd_arg), .rsp_type_i (rsp_type), .crc_check_en_i (crc_check_en),
    .index_check_en_i (index_check_en), .clk_div_i (CLK_DIV), .cmd_inhibit_o (cmd_inhibit),
    .cmd_done_o (cmd_done), .rsp_done_o (rsp_done), .rsp_word0_o (rsp_word0),
    .rsp_word1_o (rsp_word1), .rsp_word2_o (rsp_word2), .rsp_word3_o (rsp_word3),
    .err_timeout_o (err_timeout), .err_crc_o (err_crc), .err_end_bit_o (err_end_bit),
    .err_index_o (err_index), .sd_clk_o (sd_clk), .sd_cmd_o (cmd_line_host),
    .sd_cmd_en_o (cmd_line_en), .sd_cmd_i (cmd_line_card), .sd_dat0_i (sd_dat0)
  );

  sd_card_model card_i (
    .sd_clk_i (sd_clk), .cmd_i (cmd_line_host), .cmd_en_i (cmd_line_en),
    .rsp_type_i (card_rsp_type), .silent_i (card_silent), .crc_flip_i (card_crc_flip),
    .bad_index_i (card_bad_index), .busy_clks_i (card_busy_clks), .payload_i (card_payload),
    .cmd_o (cmd_line_card), .dat0_o (sd_dat0), .frame_o (card_frame),
    .frame_cnt_o (card_frames)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  //////////////////////////////
  // pulse monitor and watchdog
  //////////////////////////////

  always @(negedge clk) begin
    cycles = cycles + 1;
    if (cmd_done) seen[CMD_DONE]++;
    if (rsp_done) seen[RSP_DONE]++;
    if (err_timeout) seen[ERR_TMO]++;
    if (err_crc) seen[ERR_CRC]++;
    if (err_end_bit) seen[ERR_END]++;
    if (err_index) seen[ERR_IDX]++;
    if (rsp_done && !sd_dat0) seen[DONE_IN_BUSY]++;
    if (!sd_dat0) seen[DAT0_LOW]++;
    if (cycles > CYCLE_LIMIT) begin
      $display("timeout: the tests did not end within %0d cycles", CYCLE_LIMIT);
      $display("Finished with errors");
      $finish;
    end
  end

  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};  // taps 32, 22, 2, 1
  endfunction

  task automatic take_bits(input int n, output logic [119:0] v);
    v = '0;
    repeat (n) begin
      lfsr = lfsr_step(lfsr);
      v    = {v[118:0], lfsr[0]};
    end
  endtask

  // expected command frame: start, transmission, index, argument, crc7, end
  function automatic logic [47:0] cmd_frame(input logic [5:0] idx, input logic [31:0] arg);
    logic [39:0] msg;
    logic [6:0]  crc;
    logic        fb;
    msg = {2'b01, idx, arg};
    crc = '0;
    for (int i = 39; i >= 0; i--) begin
      fb  = msg[i] ^ crc[6];
      crc = {crc[5:0], 1'b0} ^ (fb ? 7'h09 : 7'h00);
    end
    return {msg, crc, 1'b1};
  endfunction

  function automatic logic pulsed(input int k);
    return seen[k] != base[k];
  endfunction

  function automatic logic pulsed_once(input int k);
    return seen[k] == base[k] + 1;
  endfunction

  task automatic report_failure(input string what);
    $display("%s", what);
    errors++;
    test_ok = 1'b0;
  endtask

  task automatic check_word(input string name, input logic [31:0] act, input logic [31:0] exp);
    checks++;
    if (act !== exp) report_failure($sformatf("mismatch %s: got %h, expected %h", name, act, exp));
  endtask

  task automatic check_flag(input string name, input logic act, input logic exp);
    checks++;
    if (act !== exp) report_failure($sformatf("mismatch %s: got %h, expected %h", name, act, exp));
  endtask

  task automatic check_frame(input logic [47:0] act, input logic [47:0] exp);
    checks++;
    if (act !== exp) report_failure($sformatf("mismatch card frame: got %h, expected %h", act, exp));
  endtask

  task automatic check_errors(input logic tmo, input logic crc, input logic idx);
    check_flag("err_timeout_o", pulsed(ERR_TMO), tmo);
    check_flag("err_crc_o", pulsed(ERR_CRC), crc);
    check_flag("err_index_o", pulsed(ERR_IDX), idx);
    check_flag("err_end_bit_o", pulsed(ERR_END), 1'b0);
  endtask

  task automatic strobe_cmd(input logic [5:0] idx, input logic [31:0] arg, input rsp_type_e rt,
                            input logic crc_en, input logic idx_en);
    @(posedge clk);
    #1;
    cmd_index      = idx;
    cmd_arg        = arg;
    rsp_type       = rt;
    crc_check_en   = crc_en;
    index_check_en = idx_en;
    card_rsp_type  = rt;
    cmd_start      = 1'b1;
    @(posedge clk);
    #1;
    cmd_start = 1'b0;
  endtask

  task automatic run_exchange(input logic [5:0] idx, input logic [31:0] arg, input rsp_type_e rt,
                              input logic crc_en, input logic idx_en);
    base = seen;
    strobe_cmd(idx, arg, rt, crc_en, idx_en);
    while (seen[CMD_DONE] == base[CMD_DONE]) @(posedge clk);
    check_flag("rsp_done_o", pulsed(RSP_DONE), 1'b0);  // must come after cmd_done_o
    while (seen[RSP_DONE] == base[RSP_DONE]) @(posedge clk);
  endtask

  task automatic end_test(input string name);
    tests++;
    $display("test %0d %-24s %s", tests, name, test_ok ? "ok" : "failed");
    test_ok = 1'b1;
  endtask

  //////////////////////////////
  // directed tests
  //////////////////////////////

  task automatic test_no_response();
    logic [119:0] r;
    take_bits(32, r);
    run_exchange(6'd0, r[31:0], RSP_NONE, 1'b1, 1'b1);
    check_frame(card_frame, cmd_frame(6'd0, r[31:0]));
    check_flag("cmd_done_o once", pulsed_once(CMD_DONE), 1'b1);
    check_errors(1'b0, 1'b0, 1'b0);
    end_test("no response");
  endtask

  task automatic test_short();
    logic [119:0] r;
    take_bits(32, r);
    take_bits(120, card_payload);
    run_exchange(6'd13, r[31:0], RSP_SHORT, 1'b1, 1'b1);
    check_frame(card_frame, cmd_frame(6'd13, r[31:0]));
    check_word("rsp_word0_o", rsp_word0, card_payload[31:0]);
    check_errors(1'b0, 1'b0, 1'b0);
    end_test("short response");
  endtask

  task automatic test_long();
    take_bits(120, card_payload);
    run_exchange(6'd2, 32'h0, RSP_LONG, 1'b1, 1'b1);
    check_word("rsp_word0_o", rsp_word0, card_payload[31:0]);
    check_word("rsp_word1_o", rsp_word1, card_payload[63:32]);
    check_word("rsp_word2_o", rsp_word2, card_payload[95:64]);
    check_word("rsp_word3_o", rsp_word3, {8'h00, card_payload[119:96]});
    check_errors(1'b0, 1'b0, 1'b0);
    end_test("long response");
  endtask

  task automatic test_silent();
    logic [119:0] r;
    int unsigned  frames0;
    take_bits(64, r);
    card_silent = 1'b1;
    frames0     = card_frames;
    base        = seen;
    strobe_cmd(6'd8, r[31:0], RSP_SHORT, 1'b1, 1'b1);
    repeat (4) @(posedge clk);
    #1;
    check_flag("cmd_inhibit_o", cmd_inhibit, 1'b1);
    strobe_cmd(6'd55, r[63:32], RSP_SHORT, 1'b1, 1'b1);  // dropped while inhibited
    while (seen[RSP_DONE] == base[RSP_DONE]) @(posedge clk);
    check_errors(1'b1, 1'b0, 1'b0);
    repeat (200) @(posedge clk);
    check_frame(card_frame, cmd_frame(6'd8, r[31:0]));  // first command went out whole
    checks++;
    if (card_frames != frames0 + 1) begin
      report_failure("a start strobe issued while cmd_inhibit_o was high sent a second frame");
    end
    card_silent = 1'b0;
    end_test("silent card");
  endtask

  task automatic test_faults();
    take_bits(120, card_payload);
    card_crc_flip = 1'b1;
    run_exchange(6'd13, 32'h0001_0000, RSP_SHORT, 1'b1, 1'b1);
    check_errors(1'b0, 1'b1, 1'b0);
    card_crc_flip  = 1'b0;
    card_bad_index = 1'b1;
    run_exchange(6'd13, 32'h0001_0000, RSP_SHORT, 1'b1, 1'b1);
    check_errors(1'b0, 1'b0, 1'b1);
    run_exchange(6'd13, 32'h0001_0000, RSP_SHORT, 1'b1, 1'b0);
    check_errors(1'b0, 1'b0, 1'b0);
    card_bad_index = 1'b0;
    end_test("crc and index faults");
  endtask

  task automatic test_busy();
    take_bits(120, card_payload);
    card_busy_clks = 20;
    run_exchange(6'd7, 32'h0001_0000, RSP_SHORT_BUSY, 1'b1, 1'b1);
    check_flag("sd_dat0_i busy", pulsed(DAT0_LOW), 1'b1);
    check_flag("rsp_done_o during busy", pulsed(DONE_IN_BUSY), 1'b0);
    check_word("rsp_word0_o", rsp_word0, card_payload[31:0]);
    check_errors(1'b0, 1'b0, 1'b0);
    end_test("busy on dat0");
  endtask

  initial begin
    rst_n          = 1'b0;
    cmd_start      = 1'b0;
    cmd_index      = '0;
    cmd_arg        = '0;
    rsp_type       = RSP_NONE;
    crc_check_en   = 1'b0;
    index_check_en = 1'b0;
    card_rsp_type  = RSP_NONE;
    card_silent    = 1'b0;
    card_crc_flip  = 1'b0;
    card_bad_index = 1'b0;
    card_busy_clks = 0;
    card_payload   = '0;
    lfsr           = 32'hbf08d705;
    test_ok        = 1'b1;
    repeat (5) @(posedge clk);
    #1;
    rst_n = 1'b1;
    check_flag("cmd_inhibit_o", cmd_inhibit, 1'b0);
    check_flag("sd_cmd_en_o", cmd_line_en, 1'b0);
    test_no_response();
    test_short();
    test_long();
    test_silent();
    test_faults();
    test_busy();
    $display("%0d tests, %0d checks, %0d errors", tests, checks, errors);
    if (errors == 0) begin
      $display("Finished with no errors");
    end else begin
      $display("Finished with errors");
    end
    $finish;
  end

endmodule
